/* rtl/fir_cfg.svh */
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

`define FIR_TAPS      16                 // Must be even
`define FIR_HALF      (`FIR_TAPS / 2)    // Taps per MAC engine
`define FIR_SAMPLE_W  16
`define FIR_COEF_W    16
`define FIR_ACC_W     40
`define FIR_SHIFT     15                 // Q15 coefficients
`define FIR_ADR_W     8                  // Wishbone word address width
`define FIR_DAT_W     32

`define FIR_ADR_STATUS  8'h00
`define FIR_ADR_SAMPLE  8'h01
`define FIR_ADR_RESULT  8'h02
`define FIR_ADR_COEF    8'h10            // Coefficient 0, the rest follow

`endif

/* rtl/fir_pkg.sv */
`include "fir_cfg.svh"

package fir_pkg;

	typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`FIR_COEF_W-1:0]   coef_t;
	typedef logic signed [`FIR_ACC_W-1:0]    acc_t;

	// Index 0 holds the newest sample
	typedef sample_t [`FIR_TAPS-1:0] sample_vec_t;
	typedef coef_t   [`FIR_TAPS-1:0] coef_vec_t;

	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [`FIR_ADR_W-1:0] adr;
		logic [`FIR_DAT_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                  ack;
		logic [`FIR_DAT_W-1:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic valid;
		acc_t sum;
	} part_sum_t;

	typedef enum logic [2:0] {REG_STATUS, REG_SAMPLE, REG_RESULT, REG_COEF, REG_NONE} reg_sel_e;

	typedef enum logic [1:0] {FIR_IDLE, FIR_PUSH, FIR_BUSY} fir_state_e;

endpackage

/* rtl/tap_delay_line.sv */
`timescale 1ns/1ns
`include "fir_cfg.svh"

module tap_delay_line
	import fir_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        shift_en,
	input  sample_t     shift_sample,
	output sample_vec_t taps
);

	// Every stage is visible at once, so the MACs can index any of them
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			taps <= '0;
		end
		else if (shift_en)
		begin
			taps <= {taps[`FIR_TAPS-2:0], shift_sample};    // Oldest falls off the top
		end
	end

endmodule

/* rtl/partial_mac.sv */
`timescale 1ns/1ns
`include "fir_cfg.svh"

module partial_mac
	import fir_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start,
	input  sample_t [`FIR_HALF-1:0]  taps,
	input  coef_t   [`FIR_HALF-1:0]  coefs,
	output part_sum_t                part
);

	localparam int CNT_W = $clog2(`FIR_HALF);

	logic [CNT_W-1:0] cnt;
	logic             run;
	logic             valid_q;
	acc_t             acc_q;
	acc_t             prod;

	// One tap per cycle, selected by the step counter
	assign prod = acc_t'(taps[cnt]) * acc_t'(coefs[cnt]);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Start loads product 0, the last step lands FIR_HALF cycles after start
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt     <= '0;
			run     <= 1'b0;
			valid_q <= 1'b0;
			acc_q   <= '0;
		end
		else
		begin
			valid_q <= 1'b0;
			if (start)
			begin
				acc_q <= prod;                  // cnt idles at zero
				cnt   <= CNT_W'(1);
				run   <= 1'b1;
			end
			else if (run)
			begin
				acc_q <= acc_q + prod;
				if (cnt == CNT_W'(`FIR_HALF-1))
				begin
					cnt     <= '0;
					run     <= 1'b0;
					valid_q <= 1'b1;
				end
				else
				begin
					cnt <= cnt + CNT_W'(1);
				end
			end
		end
	end

	assign part.valid = valid_q;
	assign part.sum   = acc_q;

endmodule

/* rtl/sum_combiner.sv */
`timescale 1ns/1ns
`include "fir_cfg.svh"

module sum_combiner
	import fir_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  part_sum_t part_new,
	input  part_sum_t part_old,
	output sample_t   result,
	output logic      result_valid
);

	localparam acc_t SAT_MAX = acc_t'((64'sd1 <<< (`FIR_SAMPLE_W-1)) - 64'sd1);
	localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);

	acc_t    total;
	acc_t    scaled;
	sample_t sat;

	always_comb
	begin
		total  = part_new.sum + part_old.sum;
		scaled = total >>> `FIR_SHIFT;          // Arithmetic, rounds toward minus infinity
		if (scaled > SAT_MAX)
			sat = sample_t'(SAT_MAX);
		else if (scaled < SAT_MIN)
			sat = sample_t'(SAT_MIN);
		else
			sat = sample_t'(scaled);
	end

	// Result holds until the next pair of partial sums
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			result       <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= part_new.valid && part_old.valid;
			if (part_new.valid && part_old.valid)
				result <= sat;
		end
	end

endmodule

/* rtl/fir_wb_regs.sv */
`timescale 1ns/1ns
`include "fir_cfg.svh"

module fir_wb_regs
	import fir_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  wb_req_t   wb_req,
	output wb_rsp_t   wb_rsp,
	output logic      shift_en,
	output sample_t   shift_sample,
	output logic      start,
	output coef_vec_t coefs,
	input  sample_t   result,
	input  logic      result_valid
);

	localparam int IDX_W = $clog2(`FIR_TAPS);

	reg_sel_e              sel;
	fir_state_e            state;
	logic [`FIR_ADR_W-1:0] coef_off;
	logic [IDX_W-1:0]      coef_idx;
	logic                  busy;
	logic                  res_flag;
	logic                  ack_q;
	logic                  accept;
	logic [`FIR_DAT_W-1:0] rdat;
	logic [`FIR_DAT_W-1:0] rdat_q;

	assign coef_off = wb_req.adr - `FIR_ADR_W'(`FIR_ADR_COEF);
	assign coef_idx = coef_off[IDX_W-1:0];

	always_comb
	begin
		if (wb_req.adr == `FIR_ADR_STATUS)
			sel = REG_STATUS;
		else if (wb_req.adr == `FIR_ADR_SAMPLE)
			sel = REG_SAMPLE;
		else if (wb_req.adr == `FIR_ADR_RESULT)
			sel = REG_RESULT;
		else if (wb_req.adr >= `FIR_ADR_COEF && wb_req.adr < `FIR_ADR_COEF + `FIR_TAPS)
			sel = REG_COEF;
		else
			sel = REG_NONE;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshake, a sample write waits for FIR_IDLE
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign busy   = (state != FIR_IDLE);
	assign accept = wb_req.cyc && wb_req.stb && !ack_q
		&& !(wb_req.we && sel == REG_SAMPLE && busy);

	assign shift_en     = accept && wb_req.we && sel == REG_SAMPLE;    // Shifts on the ack edge
	assign shift_sample = sample_t'(wb_req.dat[`FIR_SAMPLE_W-1:0]);
	assign start        = (state == FIR_PUSH);

	always_comb
	begin
		case (sel)
			REG_STATUS: rdat = {{(`FIR_DAT_W-2){1'b0}}, res_flag, busy};
			REG_RESULT: rdat = {{(`FIR_DAT_W-`FIR_SAMPLE_W){result[`FIR_SAMPLE_W-1]}}, result};
			REG_COEF:   rdat = {{(`FIR_DAT_W-`FIR_COEF_W){1'b0}}, coefs[coef_idx]};
			default:    rdat = '0;    // Sample register is write only
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state    <= FIR_IDLE;
			ack_q    <= 1'b0;
			res_flag <= 1'b0;
		end
		else
		begin
			ack_q <= accept;
			case (state)
				FIR_IDLE: if (shift_en) state <= FIR_PUSH;
				FIR_PUSH: state <= FIR_BUSY;
				FIR_BUSY: if (result_valid) state <= FIR_IDLE;
				default:  state <= FIR_IDLE;
			endcase
			if (result_valid)
				res_flag <= 1'b1;    // A new result wins over a read on the same edge
			else if (accept && !wb_req.we && sel == REG_RESULT)
				res_flag <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept && wb_req.we && sel == REG_COEF)
			coefs[coef_idx] <= coef_t'(wb_req.dat[`FIR_COEF_W-1:0]);
		if (accept)
			rdat_q <= rdat;
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdat_q;

endmodule

/* rtl/fir_wb_top.sv */
`timescale 1ns/1ns
`include "fir_cfg.svh"

module fir_wb_top
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	logic        shift_en;
	sample_t     shift_sample;
	sample_vec_t taps;
	logic        start;
	coef_vec_t   coefs;
	part_sum_t   part_new;
	part_sum_t   part_old;
	sample_t     result;
	logic        result_valid;

	fir_wb_regs regs0 (
		.clk(clk), .reset(reset),
		.wb_req(wb_req), .wb_rsp(wb_rsp),
		.shift_en(shift_en), .shift_sample(shift_sample),
		.start(start), .coefs(coefs),
		.result(result), .result_valid(result_valid)
	);

	tap_delay_line line0 (
		.clk(clk), .reset(reset),
		.shift_en(shift_en), .shift_sample(shift_sample), .taps(taps)
	);

	// Newest half of the history
	partial_mac mac_new (
		.clk(clk), .reset(reset), .start(start),
		.taps(taps[`FIR_HALF-1:0]), .coefs(coefs[`FIR_HALF-1:0]), .part(part_new)
	);

	partial_mac mac_old (
		.clk(clk), .reset(reset), .start(start),
		.taps(taps[`FIR_TAPS-1:`FIR_HALF]), .coefs(coefs[`FIR_TAPS-1:`FIR_HALF]),
		.part(part_old)
	);

	sum_combiner comb0 (
		.clk(clk), .reset(reset),
		.part_new(part_new), .part_old(part_old),
		.result(result), .result_valid(result_valid)
	);

endmodule

/* verif/fir_sva.sv */
`timescale 1ns/1ns
`include "fir_cfg.svh"

module fir_sva
	import fir_pkg::*;
(
	input logic    clk,
	input logic    reset,
	input wb_req_t wb_req,
	input wb_rsp_t wb_rsp,
	input logic    start,
	input logic    result_valid
);

	int fail_count = 0;    // Assertion failures so far

	// Slave only answers a live request
	ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
		else
		begin
			fail_count++;
			$error("ack raised without cyc and stb");
		end

	ack_single: assert property (@(posedge clk) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
		else
		begin
			fail_count++;
			$error("ack held for two cycles");
		end

	// Both MACs take FIR_HALF cycles, the combiner one more
	engine_latency: assert property (@(posedge clk) disable iff (reset)
		start |-> ##(`FIR_HALF + 1) result_valid)
		else
		begin
			fail_count++;
			$error("result_valid not FIR_HALF plus 1 cycles after start");
		end

endmodule

bind fir_wb_regs fir_sva sva0 (
	.clk(clk),
	.reset(reset),
	.wb_req(wb_req),
	.wb_rsp(wb_rsp),
	.start(start),
	.result_valid(result_valid)
);

/* verif/fir_tb.sv */
`timescale 1ns/1ns
`include "fir_cfg.svh"

module fir_tb
	import fir_pkg::*;
();

	// Evaluations: impulse, random run, two saturation runs, back-to-back pair
	localparam int N_EVALS     = `FIR_TAPS + 40 + 2 * `FIR_TAPS + 2;
	localparam int CYCLE_LIMIT = 40 * N_EVALS + 200;
	localparam longint SAT_MAX = (64'sd1 <<< (`FIR_SAMPLE_W - 1)) - 1;
	localparam longint SAT_MIN = -SAT_MAX - 1;

	logic        clk;
	logic        reset;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	integer      seed;
	int          cycles;
	int          pending;
	logic [31:0] exp_result;
	logic [31:0] last_result;
	longint      hist[`FIR_TAPS];    // Index 0 newest
	longint      coef_ref[`FIR_TAPS];

	fir_wb_top dut0 (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	initial
		clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
		else if (dut0.regs0.sva0.fail_count != 0)
		begin
			$display("A bound assertion on the Wishbone port or engine timing failed");
			$display("TEST FAIL");
			$fatal(1, "run stopped by an assertion failure");
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] fir_ref();
		longint acc;
		longint scaled;
		int     i;
		acc = 0;
		for (i = 0; i < `FIR_TAPS; i++)
			acc += hist[i] * coef_ref[i];
		scaled = acc >>> `FIR_SHIFT;
		if (scaled > SAT_MAX)
			scaled = SAT_MAX;
		else if (scaled < SAT_MIN)
			scaled = SAT_MIN;
		return 32'(scaled);    // Sign extended like the result register
	endfunction

	function automatic logic [15:0] rand16();
		return 16'($random(seed));
	endfunction

	task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// Request driven on the falling edge, held through the edge that samples ack
	task automatic bus_xfer(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		@(negedge clk);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		@(negedge clk);
		while (!wb_rsp.ack)
			@(negedge clk);
		rdat = wb_rsp.dat;
		@(negedge clk);
		wb_req = '0;
	endtask

	task automatic bus_write(input logic [7:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_xfer(1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input logic [7:0] adr, output logic [31:0] rdat);
		bus_xfer(1'b0, adr, 32'h0, rdat);
	endtask

	task automatic set_coef(input int idx, input logic [15:0] value);
		bus_write(8'(`FIR_ADR_COEF + idx), {16'h0000, value});
		coef_ref[idx] = longint'($signed(value));
	endtask

	task automatic push_sample(input logic [15:0] value);
		int i;
		bus_write(`FIR_ADR_SAMPLE, {{16{value[15]}}, value});
		for (i = `FIR_TAPS - 1; i > 0; i--)
			hist[i] = hist[i-1];
		hist[0] = longint'($signed(value));
	endtask

	// Hands the expected value to the compare process and waits for it
	task automatic await_result();
		exp_result = fir_ref();
		pending = 1;
		wait (pending == 0);
	endtask

	initial
	begin : compare_proc
		logic [31:0] status;
		logic [31:0] res;
		forever
		begin
			wait (pending == 1);
			status = '0;
			while (status[1:0] !== 2'b10)    // Idle with a fresh result
				bus_read(`FIR_ADR_STATUS, status);
			bus_read(`FIR_ADR_RESULT, res);
			check_equal("result", exp_result, res);
			last_result = res;
			pending = 0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial
	begin : stimulus
		logic [31:0] rd;
		int          i;
		wb_req  = '0;
		reset   = 1'b1;
		seed    = 74;
		cycles  = 0;
		pending = 0;
		for (i = 0; i < `FIR_TAPS; i++)
		begin
			hist[i]     = 0;
			coef_ref[i] = 0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		bus_read(`FIR_ADR_STATUS, rd);
		check_equal("status", 32'h0, rd);
		bus_read(`FIR_ADR_RESULT, rd);
		check_equal("result", 32'h0, rd);

		for (i = 0; i < `FIR_TAPS; i++)
			set_coef(i, rand16());
		for (i = 0; i < `FIR_TAPS; i++)
		begin
			bus_read(8'(`FIR_ADR_COEF + i), rd);
			check_equal("coef", {16'h0000, 16'(coef_ref[i])}, rd);
		end
		bus_read(8'h03, rd);
		check_equal("unmapped 0x03", 32'h0, rd);
		bus_read(8'h0f, rd);
		check_equal("unmapped 0x0f", 32'h0, rd);
		bus_read(8'(`FIR_ADR_COEF + `FIR_TAPS), rd);
		check_equal("unmapped past coefs", 32'h0, rd);
		bus_read(8'hff, rd);
		check_equal("unmapped 0xff", 32'h0, rd);

		// Impulse walks through every tap, newest half first
		for (i = 0; i < `FIR_TAPS; i++)
		begin
			push_sample((i == 0) ? 16'h7fff : 16'h0000);
			await_result();
			check_equal("impulse tap", 32'((32'sd32767 * coef_ref[i]) >>> `FIR_SHIFT), last_result);
		end

		for (i = 0; i < `FIR_TAPS; i++)
			set_coef(i, rand16());
		for (i = 0; i < 40; i++)
		begin
			push_sample(rand16());
			await_result();
		end

		for (i = 0; i < `FIR_TAPS; i++)
			set_coef(i, 16'h7fff);
		for (i = 0; i < `FIR_TAPS; i++)
		begin
			push_sample(16'h7fff);
			await_result();
		end
		check_equal("positive saturation", 32'h0000_7fff, last_result);
		for (i = 0; i < `FIR_TAPS; i++)
		begin
			push_sample(16'h8000);
			await_result();
		end
		check_equal("negative saturation", 32'hffff_8000, last_result);

		// Second write lands while the first evaluation is still running
		for (i = 0; i < `FIR_TAPS; i++)
			set_coef(i, rand16());
		push_sample(rand16());
		push_sample(rand16());
		bus_read(`FIR_ADR_STATUS, rd);
		check_equal("status busy", 32'h1, {31'h0, rd[0]});
		await_result();

		if (dut0.regs0.sva0.fail_count == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("TEST FAIL");
			$fatal(1, "a bound assertion failed near the end of the run");
		end
	end

endmodule

/* list.f */
+incdir+rtl
rtl/fir_pkg.sv
rtl/tap_delay_line.sv
rtl/partial_mac.sv
rtl/sum_combiner.sv
rtl/fir_wb_regs.sv
rtl/fir_wb_top.sv
verif/fir_sva.sv
verif/fir_tb.sv

/* Bender.yml */
package:
  name: fir_wb

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fir_pkg.sv
      - rtl/tap_delay_line.sv
      - rtl/partial_mac.sv
      - rtl/sum_combiner.sv
      - rtl/fir_wb_regs.sv
      - rtl/fir_wb_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/fir_sva.sv
      - verif/fir_tb.sv
